/* hw/max3421_settings.svh */
`ifndef MAX3421_SETTINGS_SVH
`define MAX3421_SETTINGS_SVH

// Core clocks per half SPI clock period
`define MAX_SPI_HALF_DIV 4

// Idle cycles after bus sample, before the first control transfer
`define MAX_INIT_WAIT 64

// Idle cycles after a SETUP or STATUS launch, giving the device time to answer
`define MAX_XFER_WAIT 32

// Idle cycles between a bulk IN launch and the byte count read
`define MAX_POLL_WAIT 48

// Oscillator polls before the bring-up gives up
`define MAX_OSC_POLL_LIMIT 16

// Address handed to the device by SET_ADDRESS
`define MAX_DEV_ADDR 8'h25

// Configuration value sent by SET_CONFIGURATION
`define MAX_DEV_CONFIG 8'h01

// Longest chip access: SUDFIFO command byte plus 8 SETUP bytes
`define MAX_CMD_BYTES 9

`endif

/* hw/max3421_pkg.sv */
`default_nettype none

package max3421_pkg;

  // One byte on the SPI link
  typedef logic [7:0] spi_byte_t;

  // MAX3421E register number, bits 7:3 of the command byte
  typedef logic [4:0] reg_addr_t;

  // Byte count of a single SPI frame
  typedef logic [3:0] cmd_len_t;

  // HRSLT field from the HRSL register
  typedef logic [3:0] hrslt_t;

  // Received byte count from RCVBC
  typedef logic [7:0] rcv_count_t;

  // Every chip access the sequencer can ask for
  typedef enum logic [4:0] {
    // Writes
    CMD_FULLDUPLEX,
    CMD_CHIP_RESET,
    CMD_CHIP_UNRESET,
    CMD_POWER,
    CMD_HOSTMODE,
    CMD_IRQ_ENABLE,
    CMD_SAMPLEBUS,
    CMD_PERADDR,
    CMD_SUD_SETADDR,
    CMD_SUD_SETCONFIG,
    CMD_HXFR_SETUP,
    CMD_HXFR_STATUS,
    CMD_HXFR_BULKIN,
    CMD_IRQ_CLEAR,
    // Reads
    CMD_READ_OSC,
    CMD_READ_HRSL,
    CMD_READ_RCVBC
  } cmd_id_t;

endpackage

`default_nettype wire

/* hw/max3421_cmd_rom.sv */
`timescale 1ns/100ps
`default_nettype none

`include "max3421_settings.svh"

module max3421_cmd_rom (
  input  max3421_pkg::cmd_id_t   cmd_id,
  output max3421_pkg::spi_byte_t cmd_bytes [`MAX_CMD_BYTES],
  output max3421_pkg::cmd_len_t  cmd_len
);
  import max3421_pkg::*;

  // Chip register numbers
  localparam reg_addr_t REG_SUDFIFO = 5'd4;
  localparam reg_addr_t REG_RCVBC   = 5'd6;
  localparam reg_addr_t REG_USBIRQ  = 5'd13;
  localparam reg_addr_t REG_USBCTL  = 5'd15;
  localparam reg_addr_t REG_PINCTL  = 5'd17;
  localparam reg_addr_t REG_IOPINS1 = 5'd20;
  localparam reg_addr_t REG_HIRQ    = 5'd25;
  localparam reg_addr_t REG_HIEN    = 5'd26;
  localparam reg_addr_t REG_MODE    = 5'd27;
  localparam reg_addr_t REG_PERADDR = 5'd28;
  localparam reg_addr_t REG_HCTL    = 5'd29;
  localparam reg_addr_t REG_HXFR    = 5'd30;
  localparam reg_addr_t REG_HRSL    = 5'd31;

  // Command byte layout: reg[4:0], 0, DIR, ACKSTAT
  function automatic spi_byte_t wr_cmd(input reg_addr_t addr);
    return {addr, 3'b010};
  endfunction

  function automatic spi_byte_t rd_cmd(input reg_addr_t addr);
    return {addr, 3'b000};
  endfunction

  always_comb begin
    // Register accesses are two bytes unless noted
    cmd_bytes = '{default: '0};
    cmd_len   = 4'd2;
    case (cmd_id)
      // FDUPSPI and POSINT
      CMD_FULLDUPLEX: begin
        cmd_bytes[0] = wr_cmd(REG_PINCTL);
        cmd_bytes[1] = 8'h14;
      end
      // CHIPRES set, then cleared
      CMD_CHIP_RESET: begin
        cmd_bytes[0] = wr_cmd(REG_USBCTL);
        cmd_bytes[1] = 8'h20;
      end
      CMD_CHIP_UNRESET: begin
        cmd_bytes[0] = wr_cmd(REG_USBCTL);
        cmd_bytes[1] = 8'h00;
      end
      // GPOUT0 switches VBUS on
      CMD_POWER: begin
        cmd_bytes[0] = wr_cmd(REG_IOPINS1);
        cmd_bytes[1] = 8'h01;
      end
      // DPPULLDN, DMPULLDN, SEPIRQ, HOST
      CMD_HOSTMODE: begin
        cmd_bytes[0] = wr_cmd(REG_MODE);
        cmd_bytes[1] = 8'hC9;
      end
      // HXFRDNIE, SNDBAVIE, RCVDAVIE
      CMD_IRQ_ENABLE: begin
        cmd_bytes[0] = wr_cmd(REG_HIEN);
        cmd_bytes[1] = 8'h8C;
      end
      CMD_SAMPLEBUS: begin
        cmd_bytes[0] = wr_cmd(REG_HCTL);
        cmd_bytes[1] = 8'h04;
      end
      CMD_PERADDR: begin
        cmd_bytes[0] = wr_cmd(REG_PERADDR);
        cmd_bytes[1] = spi_byte_t'(`MAX_DEV_ADDR);
      end
      // SETUP packet: bmRequestType, bRequest, wValue low, rest zero
      CMD_SUD_SETADDR: begin
        cmd_bytes[0] = wr_cmd(REG_SUDFIFO);
        cmd_bytes[2] = 8'h05;
        cmd_bytes[3] = spi_byte_t'(`MAX_DEV_ADDR);
        cmd_len      = 4'd9;
      end
      CMD_SUD_SETCONFIG: begin
        cmd_bytes[0] = wr_cmd(REG_SUDFIFO);
        cmd_bytes[2] = 8'h09;
        cmd_bytes[3] = spi_byte_t'(`MAX_DEV_CONFIG);
        cmd_len      = 4'd9;
      end
      // HXFR token: SETUP, HS-IN, bulk IN on EP0
      CMD_HXFR_SETUP: begin
        cmd_bytes[0] = wr_cmd(REG_HXFR);
        cmd_bytes[1] = 8'h10;
      end
      CMD_HXFR_STATUS: begin
        cmd_bytes[0] = wr_cmd(REG_HXFR);
        cmd_bytes[1] = 8'h80;
      end
      CMD_HXFR_BULKIN: begin
        cmd_bytes[0] = wr_cmd(REG_HXFR);
        cmd_bytes[1] = 8'h00;
      end
      // Clears HXFRDNIRQ, FRAMEIRQ, CONDETIRQ
      CMD_IRQ_CLEAR: begin
        cmd_bytes[0] = wr_cmd(REG_HIRQ);
        cmd_bytes[1] = 8'hE0;
      end
      // Reads get status in byte 0, register value in byte 1
      CMD_READ_OSC:   cmd_bytes[0] = rd_cmd(REG_USBIRQ);
      CMD_READ_HRSL:  cmd_bytes[0] = rd_cmd(REG_HRSL);
      CMD_READ_RCVBC: cmd_bytes[0] = rd_cmd(REG_RCVBC);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hw/max3421_spi.sv */
`timescale 1ns/100ps
`default_nettype none

`include "max3421_settings.svh"

module max3421_spi (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   cmd_valid,
  input  max3421_pkg::spi_byte_t cmd_bytes [`MAX_CMD_BYTES],
  input  max3421_pkg::cmd_len_t  cmd_len,
  input  logic                   miso,
  output logic                   credit_return,
  output max3421_pkg::spi_byte_t rsp_bytes [`MAX_CMD_BYTES],
  output logic                   n_ss,
  output logic                   sclk,
  output logic                   mosi
);
  import max3421_pkg::*;

  localparam int HALF_DIV = `MAX_SPI_HALF_DIV;
  localparam int DIV_W    = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_t;

  spi_state_t       state;
  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  cmd_len_t         byte_idx;
  cmd_len_t         len;
  spi_byte_t        tx_bytes [`MAX_CMD_BYTES];
  spi_byte_t        rx_shift;

  // Mode 0, MSB first; data is ready before the first rising edge
  assign mosi = (state == SPI_SHIFT) ? tx_bytes[byte_idx][3'd7 - bit_cnt] : 1'b0;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= SPI_IDLE;
      n_ss          <= 1'b1;
      sclk          <= 1'b0;
      div_cnt       <= '0;
      bit_cnt       <= '0;
      byte_idx      <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= 1'b0;
      case (state)
        SPI_IDLE: begin
          // Take the single credit and open the frame
          if (cmd_valid) begin
            state    <= SPI_SHIFT;
            n_ss     <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
          end
        end

        SPI_SHIFT: begin
          if (div_cnt == DIV_W'(HALF_DIV - 1)) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            if (!sclk) begin
              // Rising edge samples miso
              rx_shift <= {rx_shift[6:0], miso};
              if (bit_cnt == 3'd7) begin
                rsp_bytes[byte_idx] <= {rx_shift[6:0], miso};
              end
            end else begin
              // Falling edge moves to the next bit
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7) begin
                if (byte_idx == len - 4'd1) begin
                  state <= SPI_DONE;
                  n_ss  <= 1'b1;
                end else begin
                  byte_idx <= byte_idx + 4'd1;
                end
              end
            end
          end else begin
            div_cnt <= div_cnt + DIV_W'(1);
          end
        end

        // One cycle with n_ss high before the credit goes back
        SPI_DONE: begin
          state         <= SPI_IDLE;
          credit_return <= 1'b1;
        end

        default: state <= SPI_IDLE;
      endcase
    end
  end

  // Command payload captured with the credit
  always_ff @(posedge clk_in) begin
    if (state == SPI_IDLE && cmd_valid) begin
      tx_bytes <= cmd_bytes;
      len      <= cmd_len;
    end
  end

  // Sequencer must not send while it has no credit
  assert property (@(posedge clk_in) disable iff (rst_in)
    cmd_valid |-> state == SPI_IDLE);

  // Chip select only drops for a live frame
  assert property (@(posedge clk_in) disable iff (rst_in)
    state == SPI_IDLE |-> n_ss);

  // Clock parks low outside a frame
  assert property (@(posedge clk_in) disable iff (rst_in)
    n_ss |-> !sclk);

endmodule

`default_nettype wire

/* hw/max3421_seq.sv */
`timescale 1ns/100ps
`default_nettype none

`include "max3421_settings.svh"

module max3421_seq (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    credit_return,
  input  max3421_pkg::spi_byte_t  rsp_bytes [`MAX_CMD_BYTES],
  output max3421_pkg::cmd_id_t    cmd_id,
  output logic                    cmd_valid,
  output logic                    n_rst,
  output max3421_pkg::hrslt_t     host_result,
  output logic                    configured,
  output max3421_pkg::rcv_count_t rcv_count,
  output logic                    rcv_valid
);
  import max3421_pkg::*;

  typedef enum logic [4:0] {
    // Chip init
    ST_FULLDUPLEX,
    ST_CHIP_RESET,
    ST_CHIP_UNRESET,
    ST_OSC_POLL,
    ST_POWER,
    ST_HOSTMODE,
    ST_IRQ_ENABLE,
    ST_SAMPLEBUS,
    ST_INIT_WAIT,
    // SET_ADDRESS
    ST_ADDR_PERADDR,
    ST_ADDR_SUD,
    ST_ADDR_SETUP,
    ST_ADDR_SETUP_WAIT,
    ST_ADDR_HRSL,
    ST_ADDR_CLEAR,
    ST_ADDR_STATUS,
    ST_ADDR_STATUS_WAIT,
    ST_ADDR_DONE,
    // SET_CONFIGURATION
    ST_CFG_SUD,
    ST_CFG_SETUP,
    ST_CFG_SETUP_WAIT,
    ST_CFG_HRSL,
    ST_CFG_CLEAR,
    ST_CFG_STATUS,
    ST_CFG_STATUS_WAIT,
    ST_CFG_DONE,
    // Bulk IN loop
    ST_BULK_HXFR,
    ST_BULK_WAIT,
    ST_BULK_RCVBC,
    ST_HALT
  } seq_state_t;

  seq_state_t  state;
  seq_state_t  step_next;
  logic        credit;
  logic        is_cmd;
  logic        is_wait;
  logic [15:0] wait_len;
  logic [15:0] wait_cnt;
  logic [7:0]  osc_tries;

  // Per-state command, wait length and successor
  always_comb begin
    cmd_id    = CMD_READ_OSC;
    is_cmd    = 1'b1;
    is_wait   = 1'b0;
    wait_len  = 16'd1;
    step_next = ST_HALT;
    case (state)
      ST_FULLDUPLEX:   begin cmd_id = CMD_FULLDUPLEX;   step_next = ST_CHIP_RESET;   end
      ST_CHIP_RESET:   begin cmd_id = CMD_CHIP_RESET;   step_next = ST_CHIP_UNRESET; end
      ST_CHIP_UNRESET: begin cmd_id = CMD_CHIP_UNRESET; step_next = ST_OSC_POLL;     end
      ST_OSC_POLL:     begin cmd_id = CMD_READ_OSC;     step_next = ST_POWER;        end
      ST_POWER:        begin cmd_id = CMD_POWER;        step_next = ST_HOSTMODE;     end
      ST_HOSTMODE:     begin cmd_id = CMD_HOSTMODE;     step_next = ST_IRQ_ENABLE;   end
      ST_IRQ_ENABLE:   begin cmd_id = CMD_IRQ_ENABLE;   step_next = ST_SAMPLEBUS;    end
      ST_SAMPLEBUS:    begin cmd_id = CMD_SAMPLEBUS;    step_next = ST_INIT_WAIT;    end

      ST_ADDR_PERADDR: begin cmd_id = CMD_PERADDR;      step_next = ST_ADDR_SUD;     end
      ST_ADDR_SUD:     begin cmd_id = CMD_SUD_SETADDR;  step_next = ST_ADDR_SETUP;   end
      ST_ADDR_SETUP:   begin cmd_id = CMD_HXFR_SETUP;   step_next = ST_ADDR_SETUP_WAIT; end
      ST_ADDR_HRSL:    begin cmd_id = CMD_READ_HRSL;    step_next = ST_ADDR_CLEAR;   end
      ST_ADDR_CLEAR:   begin cmd_id = CMD_IRQ_CLEAR;    step_next = ST_ADDR_STATUS;  end
      ST_ADDR_STATUS:  begin cmd_id = CMD_HXFR_STATUS;  step_next = ST_ADDR_STATUS_WAIT; end
      ST_ADDR_DONE:    begin cmd_id = CMD_IRQ_CLEAR;    step_next = ST_CFG_SUD;      end

      ST_CFG_SUD:      begin cmd_id = CMD_SUD_SETCONFIG; step_next = ST_CFG_SETUP;   end
      ST_CFG_SETUP:    begin cmd_id = CMD_HXFR_SETUP;   step_next = ST_CFG_SETUP_WAIT; end
      ST_CFG_HRSL:     begin cmd_id = CMD_READ_HRSL;    step_next = ST_CFG_CLEAR;    end
      ST_CFG_CLEAR:    begin cmd_id = CMD_IRQ_CLEAR;    step_next = ST_CFG_STATUS;   end
      ST_CFG_STATUS:   begin cmd_id = CMD_HXFR_STATUS;  step_next = ST_CFG_STATUS_WAIT; end
      ST_CFG_DONE:     begin cmd_id = CMD_IRQ_CLEAR;    step_next = ST_BULK_HXFR;    end

      ST_BULK_HXFR:    begin cmd_id = CMD_HXFR_BULKIN;  step_next = ST_BULK_WAIT;    end
      ST_BULK_RCVBC:   begin cmd_id = CMD_READ_RCVBC;   step_next = ST_BULK_HXFR;    end

      // Idle states share the one timer
      ST_INIT_WAIT: begin
        is_cmd    = 1'b0;
        is_wait   = 1'b1;
        wait_len  = 16'(`MAX_INIT_WAIT);
        step_next = ST_ADDR_PERADDR;
      end
      ST_ADDR_SETUP_WAIT, ST_ADDR_STATUS_WAIT, ST_CFG_SETUP_WAIT, ST_CFG_STATUS_WAIT: begin
        is_cmd   = 1'b0;
        is_wait  = 1'b1;
        wait_len = 16'(`MAX_XFER_WAIT);
        case (state)
          ST_ADDR_SETUP_WAIT:  step_next = ST_ADDR_HRSL;
          ST_ADDR_STATUS_WAIT: step_next = ST_ADDR_DONE;
          ST_CFG_SETUP_WAIT:   step_next = ST_CFG_HRSL;
          default:             step_next = ST_CFG_DONE;
        endcase
      end
      ST_BULK_WAIT: begin
        is_cmd    = 1'b0;
        is_wait   = 1'b1;
        wait_len  = 16'(`MAX_POLL_WAIT);
        step_next = ST_BULK_RCVBC;
      end

      // Parked after the oscillator never came up
      default: is_cmd = 1'b0;
    endcase
  end

  // Send as soon as the credit is home
  assign cmd_valid = is_cmd && credit;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state       <= ST_FULLDUPLEX;
      credit      <= 1'b1;
      wait_cnt    <= '0;
      osc_tries   <= '0;
      n_rst       <= 1'b0;
      host_result <= '0;
      configured  <= 1'b0;
      rcv_count   <= '0;
      rcv_valid   <= 1'b0;
    end else begin
      // Chip reset pin released right after our own reset
      n_rst     <= 1'b1;
      rcv_valid <= 1'b0;

      if (cmd_valid) begin
        credit <= 1'b0;
      end
      if (credit_return) begin
        credit <= 1'b1;
      end

      if (is_wait) begin
        if (wait_cnt == wait_len - 16'd1) begin
          wait_cnt <= '0;
          state    <= step_next;
        end else begin
          wait_cnt <= wait_cnt + 16'd1;
        end
      end

      // Command states step on the returned credit
      if (credit_return) begin
        case (state)
          ST_OSC_POLL: begin
            // OSCOKIRQ is USBIRQ bit 0; otherwise the read repeats
            if (rsp_bytes[1][0]) begin
              state <= step_next;
            end else if (osc_tries == 8'(`MAX_OSC_POLL_LIMIT - 1)) begin
              state <= ST_HALT;
            end else begin
              osc_tries <= osc_tries + 8'd1;
            end
          end
          ST_ADDR_HRSL, ST_CFG_HRSL: begin
            host_result <= rsp_bytes[1][3:0];
            state       <= step_next;
          end
          ST_CFG_DONE: begin
            configured <= 1'b1;
            state      <= step_next;
          end
          ST_BULK_RCVBC: begin
            rcv_count <= rsp_bytes[1];
            rcv_valid <= 1'b1;
            state     <= step_next;
          end
          default: state <= step_next;
        endcase
      end
    end
  end

  // The engine only hands back a credit that is out
  assert property (@(posedge clk_in) disable iff (rst_in)
    credit_return |-> !credit);

endmodule

`default_nettype wire

/* hw/usb_host_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "max3421_settings.svh"

module usb_host_ctrl (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    miso,
  output logic                    n_rst,
  output logic                    n_ss,
  output logic                    sclk,
  output logic                    mosi,
  output max3421_pkg::hrslt_t     host_result,
  output logic                    configured,
  output max3421_pkg::rcv_count_t rcv_count,
  output logic                    rcv_valid
);
  import max3421_pkg::*;

  // Sequencer to command table
  cmd_id_t   cmd_id;
  spi_byte_t cmd_bytes [`MAX_CMD_BYTES];
  cmd_len_t  cmd_len;

  // Credit link to the SPI engine
  logic      cmd_valid;
  logic      credit_return;
  spi_byte_t rsp_bytes [`MAX_CMD_BYTES];

  max3421_seq u_seq (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .credit_return (credit_return),
    .rsp_bytes     (rsp_bytes),
    .cmd_id        (cmd_id),
    .cmd_valid     (cmd_valid),
    .n_rst         (n_rst),
    .host_result   (host_result),
    .configured    (configured),
    .rcv_count     (rcv_count),
    .rcv_valid     (rcv_valid)
  );

  max3421_cmd_rom u_cmd_rom (
    .cmd_id    (cmd_id),
    .cmd_bytes (cmd_bytes),
    .cmd_len   (cmd_len)
  );

  max3421_spi u_spi (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .cmd_valid     (cmd_valid),
    .cmd_bytes     (cmd_bytes),
    .cmd_len       (cmd_len),
    .miso          (miso),
    .credit_return (credit_return),
    .rsp_bytes     (rsp_bytes),
    .n_ss          (n_ss),
    .sclk          (sclk),
    .mosi          (mosi)
  );

endmodule

`default_nettype wire

/* tb/max3421_model.sv */
`timescale 1ns/100ps
`default_nettype none

// Behavioral MAX3421E SPI slave, mode 0, MSB first
module max3421_model (
  input  logic       n_ss,
  input  logic       sclk,
  input  logic       mosi,
  output logic       miso,
  input  logic [2:0] osc_delay,
  input  logic [7:0] hrsl_value,
  input  logic [7:0] rcvbc_value
);
  // Status byte clocked out during every command byte
  localparam logic [7:0] STATUS = 8'h2C;

  logic [7:0] regs [32];
  logic [7:0] frame [9];
  logic [7:0] rx;
  logic [7:0] tx;
  logic [7:0] tx_next;
  logic [3:0] bits;
  logic [3:0] nbytes;
  logic [7:0] osc_reads;
  int         i;

  // Frame log, drained by the testbench: one length, then that many bytes
  logic [3:0] len_q [$];
  logic [7:0] byte_q [$];

  initial begin
    miso      = 1'b0;
    osc_reads = 8'd0;
    rx        = 8'd0;
    tx_next   = 8'd0;
    foreach (regs[k]) begin
      regs[k] = 8'd0;
    end
    forever begin
      @(negedge n_ss);
      // First bit must be ready before the first rising sclk
      tx     = STATUS;
      miso   = tx[7];
      bits   = 4'd0;
      nbytes = 4'd0;
      while (!n_ss) begin
        @(posedge sclk or posedge n_ss);
        if (!n_ss) begin
          rx   = {rx[6:0], mosi};
          bits = bits + 4'd1;
          if (bits == 4'd8) begin
            if (nbytes < 4'd9) begin
              frame[nbytes] = rx;
            end
            tx_next = 8'd0;
            // Command byte with DIR clear is a read
            if (nbytes == 4'd0 && !rx[1]) begin
              case (rx[7:3])
                // USBIRQ, OSCOKIRQ comes up after a set number of polls
                5'd13: begin
                  tx_next   = (osc_reads < {5'd0, osc_delay}) ? 8'h00 : 8'h01;
                  osc_reads = osc_reads + 8'd1;
                end
                5'd31:   tx_next = hrsl_value;
                5'd6:    tx_next = rcvbc_value;
                default: tx_next = regs[rx[7:3]];
              endcase
            end
            nbytes = nbytes + 4'd1;
            bits   = 4'd0;
          end
          @(negedge sclk or posedge n_ss);
          // Next byte loads right after the last bit of the previous one
          if (bits == 4'd0) begin
            tx = tx_next;
          end else begin
            tx = tx << 1;
          end
          miso = tx[7];
        end
      end
      len_q.push_back(nbytes);
      for (i = 0; i < int'(nbytes) && i < 9; i++) begin
        byte_q.push_back(frame[i]);
      end
      // Register writes land in the register file
      if (nbytes >= 4'd2 && frame[0][1]) begin
        regs[frame[0][7:3]] = frame[1];
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_usb_host_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "max3421_settings.svh"

module tb_usb_host_ctrl;
  import max3421_pkg::*;

  // Chip registers seen on the link
  localparam reg_addr_t REG_SUDFIFO = 5'd4;
  localparam reg_addr_t REG_RCVBC   = 5'd6;
  localparam reg_addr_t REG_USBIRQ  = 5'd13;
  localparam reg_addr_t REG_USBCTL  = 5'd15;
  localparam reg_addr_t REG_PINCTL  = 5'd17;
  localparam reg_addr_t REG_IOPINS1 = 5'd20;
  localparam reg_addr_t REG_HIRQ    = 5'd25;
  localparam reg_addr_t REG_HIEN    = 5'd26;
  localparam reg_addr_t REG_MODE    = 5'd27;
  localparam reg_addr_t REG_PERADDR = 5'd28;
  localparam reg_addr_t REG_HCTL    = 5'd29;
  localparam reg_addr_t REG_HXFR    = 5'd30;
  localparam reg_addr_t REG_HRSL    = 5'd31;

  localparam spi_byte_t WRITE_BIT     = 8'h02;
  localparam int        FRAME_TIMEOUT = 4000;
  localparam int        FLAG_TIMEOUT  = 100;

  logic       clk_in;
  logic       rst_in;
  logic       miso;
  logic       n_rst;
  logic       n_ss;
  logic       sclk;
  logic       mosi;
  hrslt_t     host_result;
  logic       configured;
  rcv_count_t rcv_count;
  logic       rcv_valid;

  // Model knobs
  logic [2:0] osc_delay;
  logic [7:0] hrsl_value;
  logic [7:0] rcvbc_value;

  logic [31:0] lfsr_state;
  string       test_name;
  int          tests;
  int          checks;
  int          errors;
  int          test_errors;

  // Last frame taken from the model log
  spi_byte_t fr_bytes [9];
  cmd_len_t  fr_len;

  usb_host_ctrl u_usb_host_ctrl (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .miso        (miso),
    .n_rst       (n_rst),
    .n_ss        (n_ss),
    .sclk        (sclk),
    .mosi        (mosi),
    .host_result (host_result),
    .configured  (configured),
    .rcv_count   (rcv_count),
    .rcv_valid   (rcv_valid)
  );

  max3421_model u_model (
    .n_ss        (n_ss),
    .sclk        (sclk),
    .mosi        (mosi),
    .miso        (miso),
    .osc_delay   (osc_delay),
    .hrsl_value  (hrsl_value),
    .rcvbc_value (rcvbc_value)
  );

  // 40 ns clock
  always #20 clk_in = ~clk_in;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [7:0] take_bits(input int count);
    logic [7:0] value;
    logic       fb;
    int         n;
    value = 8'd0;
    for (n = 0; n < count; n++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[6:0], fb};
    end
    return value;
  endfunction

  task automatic check_byte(input string what, input spi_byte_t expected, input spi_byte_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_hrslt(input string what, input hrslt_t expected, input hrslt_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_count(input string what, input rcv_count_t expected,
                             input rcv_count_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic check_cmd_len(input string what, input cmd_len_t expected, input cmd_len_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s %s expected %b actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic check_polls(input string what, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("CHECK FAILED %s %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  // Ends the run when the DUT stops responding
  task automatic abort_run(input string reason);
    $display("ERROR %s: %s", test_name, reason);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + 1);
    $display("Test failed");
    $finish;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
    tests++;
  endtask

  task automatic finish_test();
    if (errors == test_errors) begin
      $display("%-16s ok", test_name);
    end else begin
      $display("%-16s FAILED with %0d errors", test_name, errors - test_errors);
    end
  endtask

  // Pop the next logged frame, polling once per clock
  task automatic get_frame();
    int cycles;
    int n;
    cycles = 0;
    while (u_model.len_q.size() == 0 && cycles < FRAME_TIMEOUT) begin
      @(posedge clk_in);
      #1;
      cycles++;
    end
    if (u_model.len_q.size() == 0) begin
      abort_run("no SPI frame from the DUT within the timeout");
    end else begin
      fr_bytes = '{default: 8'h00};
      fr_len   = u_model.len_q.pop_front();
      for (n = 0; n < int'(fr_len) && n < 9; n++) begin
        fr_bytes[n] = u_model.byte_q.pop_front();
      end
    end
  endtask

  // Command byte is register << 3, bit 1 marks a write
  task automatic check_write(input reg_addr_t addr, input spi_byte_t value, input logic use_value);
    check_cmd_len("write length", 4'd2, fr_len);
    check_byte("write command", spi_byte_t'({addr, 3'b000}) | WRITE_BIT, fr_bytes[0]);
    if (use_value) begin
      check_byte("write data", value, fr_bytes[1]);
    end
  endtask

  task automatic check_read(input reg_addr_t addr);
    check_cmd_len("read length", 4'd2, fr_len);
    check_byte("read command", spi_byte_t'({addr, 3'b000}), fr_bytes[0]);
  endtask

  task automatic expect_write(input reg_addr_t addr, input spi_byte_t value);
    get_frame();
    check_write(addr, value, 1'b1);
  endtask

  task automatic expect_read(input reg_addr_t addr);
    get_frame();
    check_read(addr);
  endtask

  // SETUP packet: type 00, request, wValue low, then zeros
  task automatic expect_setup(input spi_byte_t request, input spi_byte_t value);
    spi_byte_t pkt [8];
    int        n;
    pkt    = '{default: 8'h00};
    pkt[1] = request;
    pkt[2] = value;
    get_frame();
    check_cmd_len("SUDFIFO length", 4'd9, fr_len);
    check_byte("SUDFIFO command", spi_byte_t'({REG_SUDFIFO, 3'b000}) | WRITE_BIT, fr_bytes[0]);
    for (n = 0; n < 8; n++) begin
      check_byte($sformatf("SETUP byte %0d", n), pkt[n], fr_bytes[n + 1]);
    end
  endtask

  // Common stage order of both control transfers
  task automatic run_control(input spi_byte_t request, input spi_byte_t value);
    logic [7:0] hrsl_sent;
    hrsl_sent = hrsl_value;
    expect_setup(request, value);
    expect_write(REG_HXFR, 8'h10);
    expect_read(REG_HRSL);
    get_frame();
    check_write(REG_HIRQ, 8'h00, 1'b0);
    // HRSLT is the low nibble of HRSL
    check_hrslt("host_result", hrsl_sent[3:0], host_result);
    expect_write(REG_HXFR, 8'h80);
    get_frame();
    check_write(REG_HIRQ, 8'h00, 1'b0);
  endtask

  task automatic test_reset();
    start_test("reset");
    check_flag("n_ss in reset", 1'b1, n_ss);
    check_flag("sclk in reset", 1'b0, sclk);
    rst_in = 1'b0;
    @(posedge clk_in);
    #1;
    check_flag("n_rst after reset", 1'b1, n_rst);
    finish_test();
  endtask

  task automatic test_init_start();
    start_test("init_start");
    expect_write(REG_PINCTL, 8'h14);
    expect_write(REG_USBCTL, 8'h20);
    expect_write(REG_USBCTL, 8'h00);
    finish_test();
  endtask

  // Counts USBIRQ reads until the first write frame
  task automatic test_osc_poll();
    int reads;
    start_test("osc_poll");
    reads = 0;
    get_frame();
    while (!fr_bytes[0][1] && reads < 20) begin
      check_read(REG_USBIRQ);
      reads++;
      get_frame();
    end
    // Not-ready polls, then the one poll that sees OSCOKIRQ
    check_polls("USBIRQ reads", int'(osc_delay) + 1, reads);
    finish_test();
  endtask

  task automatic test_init_finish();
    start_test("init_finish");
    // IOPINS1 frame was already taken by the poll
    check_write(REG_IOPINS1, 8'h01, 1'b1);
    expect_write(REG_MODE, 8'hC9);
    expect_write(REG_HIEN, 8'h8C);
    expect_write(REG_HCTL, 8'h04);
    finish_test();
  endtask

  task automatic test_set_address();
    start_test("set_address");
    expect_write(REG_PERADDR, `MAX_DEV_ADDR);
    run_control(8'h05, `MAX_DEV_ADDR);
    finish_test();
  endtask

  task automatic test_set_config();
    int cycles;
    start_test("set_config");
    check_flag("configured before", 1'b0, configured);
    hrsl_value = take_bits(8);
    run_control(8'h09, `MAX_DEV_CONFIG);
    cycles = 0;
    while (!configured && cycles < FLAG_TIMEOUT) begin
      @(posedge clk_in);
      #1;
      cycles++;
    end
    if (!configured) begin
      abort_run("configured never rose after SET_CONFIGURATION");
    end
    finish_test();
  endtask

  task automatic test_bulk_in();
    rcv_count_t expected;
    int         poll;
    int         cycles;
    start_test("bulk_in");
    for (poll = 0; poll < 8; poll++) begin
      expect_write(REG_HXFR, 8'h00);
      // Byte count changes before the RCVBC read starts
      rcvbc_value = take_bits(8);
      expected    = rcvbc_value;
      expect_read(REG_RCVBC);
      cycles = 0;
      while (!rcv_valid && cycles < FLAG_TIMEOUT) begin
        @(posedge clk_in);
        #1;
        cycles++;
      end
      if (!rcv_valid) begin
        abort_run("rcv_valid never pulsed after an RCVBC read");
      end
      check_count($sformatf("rcv_count poll %0d", poll), expected, rcv_count);
    end
    finish_test();
  endtask

  initial begin
    logic [7:0] pick;
    clk_in      = 1'b0;
    rst_in      = 1'b1;
    tests       = 0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    test_name   = "setup";
    lfsr_state  = 32'h57e6;
    // Oscillator ready after 1 to 7 polls
    pick        = take_bits(3);
    osc_delay   = 3'((pick % 8'd7) + 8'd1);
    hrsl_value  = take_bits(8);
    rcvbc_value = 8'h00;
    repeat (4) @(posedge clk_in);
    #1;
    test_reset();
    test_init_start();
    test_osc_poll();
    test_init_finish();
    test_set_address();
    test_set_config();
    test_bulk_in();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/max3421_pkg.sv
hw/max3421_cmd_rom.sv
hw/max3421_spi.sv
hw/max3421_seq.sv
hw/usb_host_ctrl.sv
tb/max3421_model.sv
tb/tb_usb_host_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_usb_host_ctrl

./obj_dir/Vtb_usb_host_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
